//--- all.f
flow_pkg.sv
ram_1r1w.sv
pio_rw_wmem.sv
flow_lookup.sv
flow_csr.sv
pio_bus_mux.sv
flow_subsys_top.sv
tb_flow_subsys.sv

//--- run.sh
#!/bin/sh
# Build and run the flow table testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module tb_flow_subsys -f all.f

status=0
./obj_dir/Vtb_flow_subsys > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "STATUS: FAIL" sim.log; then
	echo "Simulation failed, see sim.log"
	exit 1
fi
echo "Simulation finished without failures"

//--- tb_flow_subsys.sv
`timescale 1ns/100ps

module tb_flow_subsys;

	localparam int depth_nbits = 10;
	localparam int n_idx = 1 << depth_nbits;
	localparam int clk_period = 100;
	localparam int n_entries = 16;
	localparam int n_stream = 120;
	localparam int n_bg = 4;
	// Each host or lookup operation over all tests may take 200 cycles
	localparam int n_steps = n_entries * 6 + n_stream + n_bg * 4 + 20;

	logic clk;
	logic rst_n;
	logic pio_tick;
	flow_pkg::pio_req_t pio;
	logic lkp_valid;
	flow_pkg::lookup_req_t lkp_req;
	logic [flow_pkg::pio_nbits-1:0] pio_rdata;
	logic pio_ack;
	logic rsp_valid;
	flow_pkg::lookup_rsp_t rsp;

	// Reference model of the table and the CSR block
	flow_pkg::flow_entry_t model [0:n_idx-1];
	logic [flow_pkg::action_nbits-1:0] model_default;
	logic model_learn;
	int model_hits = 0;
	int model_misses = 0;

	// Expected responses and their issue cycles in issue order
	flow_pkg::lookup_rsp_t exp_q [$];
	int cyc_q [$];
	int cyc = 0;
	int errors = 0;
	int checks = 0;
	int tests = 0;
	int failed_tests = 0;
	logic [31:0] rng;
	logic [flow_pkg::key_nbits-1:0] ent_key [0:n_entries-1];

	flow_subsys_top #(
		.depth_nbits(depth_nbits)
	) dut_i (
		.clk(clk),
		.rst_n(rst_n),
		.pio_tick(pio_tick),
		.pio(pio),
		.lkp_valid(lkp_valid),
		.lkp_req(lkp_req),
		.pio_rdata(pio_rdata),
		.pio_ack(pio_ack),
		.rsp_valid(rsp_valid),
		.rsp(rsp)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	initial begin : watchdog
		#(n_steps * 200 * clk_period);
		$display("Timeout: the tests did not finish within %0d cycles", n_steps * 200);
		$display("STATUS: FAIL");
		$finish;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Helpers and compare tasks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Spread the test entries so that no two share an index
	function automatic logic [depth_nbits-1:0] entry_index(input int i);
		return depth_nbits'((i * 37 + 5) % n_idx);
	endfunction

	function automatic logic [31:0] table_addr(input logic [depth_nbits-1:0] idx,
		input logic hi);
		logic [31:0] a;
		a = '0;
		a[flow_pkg::index_lsb +: depth_nbits] = idx;
		a[flow_pkg::word_sel_bit] = hi;
		return a;
	endfunction

	// Flip the top key bit and keep the index
	function automatic logic [flow_pkg::key_nbits-1:0] flip_key(
		input logic [flow_pkg::key_nbits-1:0] k);
		return k ^ {1'b1, {(flow_pkg::key_nbits - 1){1'b0}}};
	endfunction

	function automatic flow_pkg::lookup_rsp_t expected_rsp(
		input logic [flow_pkg::key_nbits-1:0] k);
		flow_pkg::flow_entry_t e;
		flow_pkg::lookup_rsp_t r;
		e = model[k[depth_nbits-1:0]];
		r.hit = e.valid && (e.key == k);
		r.action = r.hit ? e.action : model_default;
		return r;
	endfunction

	task automatic check_word(input string name, input logic [flow_pkg::pio_nbits-1:0] got,
		input logic [flow_pkg::pio_nbits-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_rsp(input string name, input flow_pkg::lookup_rsp_t got,
		input flow_pkg::lookup_rsp_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic finish_test(input string name, input int err_before);
		tests++;
		if (errors == err_before) begin
			$display("%s: ok", name);
		end else begin
			failed_tests++;
			$display("%s: failed with %0d errors", name, errors - err_before);
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Host and lookup drivers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Wait at falling edges for ack to rise and then fall
	task automatic wait_ack(output logic [31:0] rdata);
		@(negedge clk);
		while (!pio_ack) begin
			@(negedge clk);
		end
		rdata = pio_rdata;
		while (pio_ack) begin
			@(negedge clk);
		end
	endtask

	task automatic pio_write(input logic [31:0] addr, input logic [31:0] data);
		logic [31:0] ack_rdata;
		@(posedge clk);
		pio.addr <= addr;
		pio.wdata <= data;
		pio.wr <= 1'b1;
		@(posedge clk);
		pio.wr <= 1'b0;
		wait_ack(ack_rdata);
	endtask

	task automatic pio_read(input logic [31:0] addr, output logic [31:0] data);
		@(posedge clk);
		pio.addr <= addr;
		pio.rd <= 1'b1;
		@(posedge clk);
		pio.rd <= 1'b0;
		wait_ack(data);
	endtask

	task automatic write_entry(input logic [depth_nbits-1:0] idx,
		input flow_pkg::flow_entry_t e);
		logic [flow_pkg::entry_nbits-1:0] bits;
		bits = e;
		pio_write(table_addr(idx, 1'b0), bits[31:0]);
		// Bits above the entry in the high word carry junk that the table drops
		pio_write(table_addr(idx, 1'b1), {~bits[31:8], bits[flow_pkg::entry_nbits-1:32]});
		model[idx] = e;
	endtask

	task automatic check_entry(input logic [depth_nbits-1:0] idx);
		logic [flow_pkg::entry_nbits-1:0] bits;
		logic [31:0] got;
		bits = model[idx];
		pio_read(table_addr(idx, 1'b0), got);
		check_word("pio_rdata low", got, bits[31:0]);
		pio_read(table_addr(idx, 1'b1), got);
		check_word("pio_rdata high", got, 32'(bits[flow_pkg::entry_nbits-1:32]));
	endtask

	task automatic lookup(input logic [flow_pkg::key_nbits-1:0] k);
		flow_pkg::lookup_rsp_t r;
		r = expected_rsp(k);
		@(posedge clk);
		lkp_valid <= 1'b1;
		lkp_req.key <= k;
		exp_q.push_back(r);
		cyc_q.push_back(cyc);
		if (r.hit) begin
			model_hits++;
		end else begin
			model_misses++;
			if (model_learn) begin
				model[k[depth_nbits-1:0]].valid = 1'b1;
				model[k[depth_nbits-1:0]].key = k;
				model[k[depth_nbits-1:0]].action = model_default;
			end
		end
	endtask

	task automatic idle_cycle();
		@(posedge clk);
		lkp_valid <= 1'b0;
	endtask

	task automatic end_stream();
		idle_cycle();
		while (exp_q.size() != 0) begin
			@(posedge clk);
		end
	endtask

	// Each response must match the queue and come 4 cycles after its request
	initial begin : rsp_monitor
		flow_pkg::lookup_rsp_t exp;
		int issued;
		forever begin
			@(negedge clk);
			if (rsp_valid === 1'b1) begin
				if (exp_q.size() == 0) begin
					errors++;
					$display("Lookup response arrived with no lookup pending");
				end else begin
					exp = exp_q.pop_front();
					issued = cyc_q.pop_front();
					if (cyc != issued + 4) begin
						errors++;
						$display("Lookup response at cycle %0d, expected at cycle %0d",
							cyc, issued + 4);
					end
					check_rsp("rsp", rsp, exp);
				end
			end
			cyc++;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Directed tests
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic test_pio_readback();
		int err_before;
		flow_pkg::flow_entry_t e;
		logic [depth_nbits-1:0] idx;
		err_before = errors;
		for (int i = 0; i < n_entries; i++) begin
			idx = entry_index(i);
			rng = xorshift32(rng);
			ent_key[i] = {rng[31 -: flow_pkg::key_nbits - depth_nbits], idx};
			// Every fourth entry stays invalid
			e.valid = (i % 4) != 3;
			e.key = ent_key[i];
			e.action = rng[15:0];
			write_entry(idx, e);
		end
		for (int i = 0; i < n_entries; i++) begin
			check_entry(entry_index(i));
		end
		finish_test("pio entry readback", err_before);
	endtask

	task automatic test_lookup_stream();
		int err_before;
		logic [31:0] got;
		err_before = errors;
		rng = xorshift32(rng);
		pio_write(flow_pkg::csr_default_addr, 32'(rng[15:0]));
		model_default = rng[15:0];
		pio_read(flow_pkg::csr_default_addr, got);
		check_word("default_action", got, 32'(model_default));
		// Stored key then mismatched key on the same index in back-to-back cycles
		for (int i = 0; i < n_entries; i++) begin
			lookup(ent_key[i]);
			lookup(flip_key(ent_key[i]));
		end
		end_stream();
		finish_test("lookup hit and miss stream", err_before);
	endtask

	task automatic test_learn();
		int err_before;
		logic [flow_pkg::key_nbits-1:0] k;
		err_before = errors;
		pio_write(flow_pkg::csr_ctrl_addr, 32'h1);
		model_learn = 1'b1;
		// Entry 3 is invalid, so a new key on its index is learned
		k = flip_key(ent_key[3]);
		lookup(k);
		end_stream();
		// Repeat lookup goes out 3 cycles after the missed response
		repeat (1) @(posedge clk);
		lookup(k);
		end_stream();
		check_entry(entry_index(3));
		// A miss on a valid entry replaces it and the old key then misses
		k = flip_key(ent_key[0]);
		lookup(k);
		end_stream();
		repeat (1) @(posedge clk);
		lookup(k);
		lookup(ent_key[0]);
		end_stream();
		pio_write(flow_pkg::csr_ctrl_addr, 32'h0);
		model_learn = 1'b0;
		check_entry(entry_index(0));
		finish_test("learn on miss", err_before);
	endtask

	task automatic test_counters(input string name);
		int err_before;
		logic [31:0] got;
		err_before = errors;
		pio_read(flow_pkg::csr_hit_addr, got);
		check_word("hit counter", got, model_hits);
		pio_read(flow_pkg::csr_miss_addr, got);
		check_word("miss counter", got, model_misses);
		finish_test(name, err_before);
	endtask

	task automatic test_concurrent();
		int err_before;
		int i;
		flow_pkg::flow_entry_t bg [0:n_bg-1];
		err_before = errors;
		// Host entries sit at the top of the table away from the lookup keys
		for (int j = 0; j < n_bg; j++) begin
			rng = xorshift32(rng);
			bg[j].valid = 1'b1;
			bg[j].key = {rng[31 -: flow_pkg::key_nbits - depth_nbits],
				depth_nbits'(n_idx - 1 - j)};
			bg[j].action = rng[15:0];
		end
		fork
			begin
				for (int n = 0; n < n_stream; n++) begin
					rng = xorshift32(rng);
					i = int'(rng[7:0]) % n_entries;
					if (rng[9:8] == 2'b00) begin
						idle_cycle();
					end else if (rng[10]) begin
						lookup(flip_key(ent_key[i]));
					end else begin
						lookup(ent_key[i]);
					end
				end
				end_stream();
			end
			begin
				for (int j = 0; j < n_bg; j++) begin
					write_entry(depth_nbits'(n_idx - 1 - j), bg[j]);
					check_entry(depth_nbits'(n_idx - 1 - j));
				end
			end
		join
		finish_test("host access under lookup traffic", err_before);
	endtask

	initial begin
		rst_n = 1'b0;
		pio = '0;
		pio_tick = 1'b1;
		lkp_valid = 1'b0;
		lkp_req = '0;
		rng = 32'hc32d522f;
		model_default = '0;
		model_learn = 1'b0;
		for (int i = 0; i < n_idx; i++) begin
			model[i] = '0;
		end
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		repeat (2) @(posedge clk);

		test_pio_readback();
		test_lookup_stream();
		test_learn();
		test_counters("hit and miss counters");
		test_concurrent();
		test_counters("counters after mixed traffic");

		$display("Tests %0d, failed %0d, checks %0d, errors %0d",
			tests, failed_tests, checks, errors);
		if (errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

//--- flow_subsys_top.sv
`timescale 1ns/100ps

module flow_subsys_top #(
	parameter int depth_nbits = 10
) (
	input  logic clk,
	input  logic rst_n,
	input  logic pio_tick,
	input  flow_pkg::pio_req_t pio,
	input  logic lkp_valid,
	input  flow_pkg::lookup_req_t lkp_req,
	output logic [flow_pkg::pio_nbits-1:0] pio_rdata,
	output logic pio_ack,
	output logic rsp_valid,
	output flow_pkg::lookup_rsp_t rsp
);

	// Host side
	logic tbl_sel;
	logic csr_sel;
	logic [flow_pkg::pio_nbits-1:0] tbl_rdata;
	logic tbl_ack;
	logic [flow_pkg::pio_nbits-1:0] csr_rdata;
	logic csr_ack;

	// Lookup control and statistics
	logic learn_en;
	logic [flow_pkg::action_nbits-1:0] default_action;
	logic hit;
	logic miss;

	// Application table port
	logic app_rd;
	logic [depth_nbits-1:0] app_raddr;
	logic app_wr;
	logic [depth_nbits-1:0] app_waddr;
	flow_pkg::flow_entry_t app_wdata;
	logic app_ack;
	flow_pkg::flow_entry_t app_rdata;

	pio_bus_mux mux_i (
		.clk(clk),
		.rst_n(rst_n),
		.pio_addr_msb(pio.addr[flow_pkg::table_region_bit]),
		.pio_strobe(pio.rd || pio.wr),
		.tbl_rdata(tbl_rdata),
		.tbl_ack(tbl_ack),
		.csr_rdata(csr_rdata),
		.csr_ack(csr_ack),
		.tbl_sel(tbl_sel),
		.csr_sel(csr_sel),
		.rdata(pio_rdata),
		.ack(pio_ack)
	);

	flow_csr csr_i (
		.clk(clk),
		.rst_n(rst_n),
		.pio_tick(pio_tick),
		.pio(pio),
		.csr_sel(csr_sel),
		.hit(hit),
		.miss(miss),
		.learn_en(learn_en),
		.default_action(default_action),
		.csr_rdata(csr_rdata),
		.csr_ack(csr_ack)
	);

	flow_lookup #(
		.depth_nbits(depth_nbits)
	) lookup_i (
		.clk(clk),
		.rst_n(rst_n),
		.lkp_valid(lkp_valid),
		.lkp_req(lkp_req),
		.app_rdata(app_rdata),
		.app_ack(app_ack),
		.learn_en(learn_en),
		.default_action(default_action),
		.rsp_valid(rsp_valid),
		.rsp(rsp),
		.app_rd(app_rd),
		.app_raddr(app_raddr),
		.app_wr(app_wr),
		.app_waddr(app_waddr),
		.app_wdata(app_wdata),
		.hit(hit),
		.miss(miss)
	);

	pio_rw_wmem #(
		.depth_nbits(depth_nbits)
	) table_i (
		.clk(clk),
		.rst_n(rst_n),
		.pio_tick(pio_tick),
		.pio(pio),
		.tbl_sel(tbl_sel),
		.app_rd(app_rd),
		.app_raddr(app_raddr),
		.app_wr(app_wr),
		.app_waddr(app_waddr),
		.app_wdata(app_wdata),
		.mem_ack(tbl_ack),
		.mem_rdata(tbl_rdata),
		.app_ack(app_ack),
		.app_rdata(app_rdata)
	);

endmodule

//--- pio_bus_mux.sv
`timescale 1ns/100ps

module pio_bus_mux (
	input  logic clk,
	input  logic rst_n,
	input  logic pio_addr_msb,
	input  logic pio_strobe,
	input  logic [flow_pkg::pio_nbits-1:0] tbl_rdata,
	input  logic tbl_ack,
	input  logic [flow_pkg::pio_nbits-1:0] csr_rdata,
	input  logic csr_ack,
	output logic tbl_sel,
	output logic csr_sel,
	output logic [flow_pkg::pio_nbits-1:0] rdata,
	output logic ack
);

	// Target of the last strobe steers the response
	logic csr_last;

	assign csr_sel = pio_addr_msb;
	assign tbl_sel = !pio_addr_msb;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			csr_last <= 1'b0;
		end else if (pio_strobe) begin
			csr_last <= pio_addr_msb;
		end
	end

	assign rdata = csr_last ? csr_rdata : tbl_rdata;
	assign ack = csr_last ? csr_ack : tbl_ack;

endmodule

//--- flow_csr.sv
`timescale 1ns/100ps

module flow_csr (
	input  logic clk,
	input  logic rst_n,
	input  logic pio_tick,
	input  flow_pkg::pio_req_t pio,
	input  logic csr_sel,
	input  logic hit,
	input  logic miss,
	output logic learn_en,
	output logic [flow_pkg::action_nbits-1:0] default_action,
	output logic [flow_pkg::pio_nbits-1:0] csr_rdata,
	output logic csr_ack
);

	logic csr_rd;
	logic csr_wr;
	logic n_ack;
	logic [flow_pkg::pio_nbits-1:0] hit_cnt;
	logic [flow_pkg::pio_nbits-1:0] miss_cnt;

	assign csr_rd = csr_sel && pio.rd;
	assign csr_wr = csr_sel && pio.wr;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Registers, counters and acknowledge
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			learn_en <= 1'b0;
			default_action <= '0;
			hit_cnt <= '0;
			miss_cnt <= '0;
			n_ack <= 1'b0;
			csr_ack <= 1'b0;
		end else begin
			if (csr_wr && pio.addr == flow_pkg::csr_ctrl_addr) begin
				learn_en <= pio.wdata[0];
			end
			if (csr_wr && pio.addr == flow_pkg::csr_default_addr) begin
				default_action <= pio.wdata[flow_pkg::action_nbits-1:0];
			end
			// Counters stick at all ones
			if (hit && hit_cnt != '1) begin
				hit_cnt <= hit_cnt + 1'b1;
			end
			if (miss && miss_cnt != '1) begin
				miss_cnt <= miss_cnt + 1'b1;
			end
			if (csr_rd || csr_wr) begin
				n_ack <= 1'b1;
			end else if (pio_tick) begin
				n_ack <= 1'b0;
			end
			if (pio_tick) begin
				csr_ack <= n_ack;
			end
		end
	end

	// Read data captured at the strobe, stable until the ack
	always_ff @(posedge clk) begin
		if (csr_rd) begin
			case (pio.addr)
				flow_pkg::csr_ctrl_addr:
					csr_rdata <= {{(flow_pkg::pio_nbits-1){1'b0}}, learn_en};
				flow_pkg::csr_default_addr:
					csr_rdata <= {{(flow_pkg::pio_nbits-flow_pkg::action_nbits){1'b0}},
						default_action};
				flow_pkg::csr_hit_addr:
					csr_rdata <= hit_cnt;
				flow_pkg::csr_miss_addr:
					csr_rdata <= miss_cnt;
				default:
					csr_rdata <= '0;
			endcase
		end
	end

endmodule

//--- flow_lookup.sv
`timescale 1ns/100ps

module flow_lookup #(
	parameter int depth_nbits = 10
) (
	input  logic clk,
	input  logic rst_n,
	input  logic lkp_valid,
	input  flow_pkg::lookup_req_t lkp_req,
	input  flow_pkg::flow_entry_t app_rdata,
	input  logic app_ack,
	input  logic learn_en,
	input  logic [flow_pkg::action_nbits-1:0] default_action,
	output logic rsp_valid,
	output flow_pkg::lookup_rsp_t rsp,
	output logic app_rd,
	output logic [depth_nbits-1:0] app_raddr,
	output logic app_wr,
	output logic [depth_nbits-1:0] app_waddr,
	output flow_pkg::flow_entry_t app_wdata,
	output logic hit,
	output logic miss
);

	logic [flow_pkg::key_nbits-1:0] key_d1;
	logic [flow_pkg::key_nbits-1:0] key_d2;
	logic [flow_pkg::key_nbits-1:0] key_d3;
	logic [flow_pkg::key_nbits-1:0] key_d4;
	logic match;
	logic learn_q;

	// Direct-mapped table, index is the low key bits
	assign app_rd = lkp_valid;
	assign app_raddr = lkp_req.key[depth_nbits-1:0];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Key pipeline, stage 3 lines up with app_ack
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		key_d1 <= lkp_req.key;
		key_d2 <= key_d1;
		key_d3 <= key_d2;
		key_d4 <= key_d3;
	end

	assign match = app_rdata.valid && (app_rdata.key == key_d3);

	// Stage 4 response payload
	always_ff @(posedge clk) begin
		rsp.hit <= match;
		rsp.action <= match ? app_rdata.action : default_action;
	end

	assign hit = rsp_valid && rsp.hit;
	assign miss = rsp_valid && !rsp.hit;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Learn write, one cycle after the missed response
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rsp_valid <= 1'b0;
			learn_q <= 1'b0;
			app_wr <= 1'b0;
		end else begin
			rsp_valid <= app_ack;
			learn_q <= app_ack && !match && learn_en;
			app_wr <= learn_q;
		end
	end

	// On a miss the response already carries the default action
	always_ff @(posedge clk) begin
		app_waddr <= key_d4[depth_nbits-1:0];
		app_wdata.valid <= 1'b1;
		app_wdata.key <= key_d4;
		app_wdata.action <= rsp.action;
	end

endmodule

//--- pio_rw_wmem.sv
`timescale 1ns/100ps

module pio_rw_wmem #(
	parameter int depth_nbits = 10
) (
	input  logic clk,
	input  logic rst_n,
	input  logic pio_tick,
	input  flow_pkg::pio_req_t pio,
	input  logic tbl_sel,
	input  logic app_rd,
	input  logic [depth_nbits-1:0] app_raddr,
	input  logic app_wr,
	input  logic [depth_nbits-1:0] app_waddr,
	input  flow_pkg::flow_entry_t app_wdata,
	output logic mem_ack,
	output logic [flow_pkg::pio_nbits-1:0] mem_rdata,
	output logic app_ack,
	output flow_pkg::flow_entry_t app_rdata
);

	localparam int hi_nbits = flow_pkg::entry_nbits - flow_pkg::pio_nbits;

	// Application side pipeline
	logic app_rd_d1;
	logic app_rd_d2;
	logic app_wr_d1;
	logic [depth_nbits-1:0] app_raddr_d1;
	logic [depth_nbits-1:0] app_waddr_d1;
	flow_pkg::flow_entry_t app_wdata_d1;

	// Host side decode and collision state
	logic host_hi;
	logic [depth_nbits-1:0] host_idx;
	logic rd_lo;
	logic rd_hi;
	logic wr_lo;
	logic wr_hi;
	logic rd_save;
	logic wr_save;
	logic rd_go;
	logic wr_go;
	logic rd_go_d1;
	logic n_ack;
	logic [flow_pkg::pio_nbits-1:0] wdata_lo;
	logic [hi_nbits-1:0] wdata_hi;
	logic [hi_nbits-1:0] rdata_hi;

	// RAM ports
	logic ram_wr;
	logic [depth_nbits-1:0] ram_raddr;
	logic [depth_nbits-1:0] ram_waddr;
	logic [flow_pkg::entry_nbits-1:0] ram_wdata;
	logic [flow_pkg::entry_nbits-1:0] ram_rdata;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Host decode
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign host_hi = pio.addr[flow_pkg::word_sel_bit];
	assign host_idx = pio.addr[flow_pkg::index_lsb +: depth_nbits];

	assign rd_lo = tbl_sel && pio.rd && !host_hi;
	assign rd_hi = tbl_sel && pio.rd && host_hi;
	assign wr_lo = tbl_sel && pio.wr && !host_hi;
	assign wr_hi = tbl_sel && pio.wr && host_hi;

	// Host gets a RAM port only when the application leaves it idle
	assign rd_go = !app_rd_d1 && (rd_lo || rd_save);
	assign wr_go = !app_wr_d1 && (wr_hi || wr_save);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// RAM port steering
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign ram_raddr = app_rd_d1 ? app_raddr_d1 : host_idx;
	assign ram_wr = app_wr_d1 || wr_go;
	assign ram_waddr = app_wr_d1 ? app_waddr_d1 : host_idx;
	// High word comes straight off the bus when the commit is not delayed
	assign ram_wdata = app_wr_d1 ? app_wdata_d1 :
		{(wr_hi ? pio.wdata[hi_nbits-1:0] : wdata_hi), wdata_lo};

	always_ff @(posedge clk) begin
		app_raddr_d1 <= app_raddr;
		app_waddr_d1 <= app_waddr;
		app_wdata_d1 <= app_wdata;
		app_rdata <= ram_rdata;
		if (wr_lo) begin
			wdata_lo <= pio.wdata;
		end
		if (wr_hi) begin
			wdata_hi <= pio.wdata[hi_nbits-1:0];
		end
		if (rd_go_d1) begin
			rdata_hi <= ram_rdata[flow_pkg::entry_nbits-1:flow_pkg::pio_nbits];
		end
		// Low word from the RAM, high word from the bits kept at the low read
		if (rd_go_d1) begin
			mem_rdata <= ram_rdata[flow_pkg::pio_nbits-1:0];
		end else if (rd_hi) begin
			mem_rdata <= {{(flow_pkg::pio_nbits-hi_nbits){1'b0}}, rdata_hi};
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Control state and acknowledge
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			app_rd_d1 <= 1'b0;
			app_rd_d2 <= 1'b0;
			app_wr_d1 <= 1'b0;
			app_ack <= 1'b0;
			rd_save <= 1'b0;
			wr_save <= 1'b0;
			rd_go_d1 <= 1'b0;
			n_ack <= 1'b0;
			mem_ack <= 1'b0;
		end else begin
			app_rd_d1 <= app_rd;
			app_rd_d2 <= app_rd_d1;
			app_wr_d1 <= app_wr;
			app_ack <= app_rd_d2;
			rd_go_d1 <= rd_go;
			// Collided host accesses wait here for a free cycle
			if (app_rd_d1 && rd_lo) begin
				rd_save <= 1'b1;
			end else if (rd_go) begin
				rd_save <= 1'b0;
			end
			if (app_wr_d1 && wr_hi) begin
				wr_save <= 1'b1;
			end else if (wr_go) begin
				wr_save <= 1'b0;
			end
			// Done flag holds until a tick has passed it on to mem_ack
			if (rd_hi || rd_go_d1 || wr_lo || wr_go) begin
				n_ack <= 1'b1;
			end else if (pio_tick) begin
				n_ack <= 1'b0;
			end
			if (pio_tick) begin
				mem_ack <= n_ack;
			end
		end
	end

	ram_1r1w #(
		.width(flow_pkg::entry_nbits),
		.depth_nbits(depth_nbits)
	) ram_i (
		.clk(clk),
		.wr(ram_wr),
		.raddr(ram_raddr),
		.waddr(ram_waddr),
		.din(ram_wdata),
		.dout(ram_rdata)
	);

	// Host waits for mem_ack before its next strobe, so a pending read is alone
	a_save_alone: assert property (@(posedge clk) disable iff (!rst_n)
		rd_save |-> !(pio.rd || pio.wr));

endmodule

//--- ram_1r1w.sv
`timescale 1ns/100ps

module ram_1r1w #(
	parameter int width = 40,
	parameter int depth_nbits = 10
) (
	input  logic clk,
	input  logic wr,
	input  logic [depth_nbits-1:0] raddr,
	input  logic [depth_nbits-1:0] waddr,
	input  logic [width-1:0] din,
	output logic [width-1:0] dout
);

	logic [width-1:0] mem [0:(1<<depth_nbits)-1];

	// One write and one registered read per cycle
	// Same-address read and write returns the old word
	always_ff @(posedge clk) begin
		if (wr) begin
			mem[waddr] <= din;
		end
		dout <= mem[raddr];
	end

	// Write address must be known whenever a write is issued
	a_waddr_known: assert property (@(posedge clk) wr |-> !$isunknown(waddr));

endmodule

//--- flow_pkg.sv
package flow_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Widths
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam int pio_nbits = 32;
	localparam int key_nbits = 23;
	localparam int action_nbits = 16;
	localparam int entry_nbits = 40;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Host address map
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Region bit clear selects the table, set selects the CSR block
	localparam int table_region_bit = 15;
	// Word select inside an entry, high word holds entry bits 39 to 32
	localparam int word_sel_bit = 2;
	localparam int index_lsb = 3;

	localparam logic [pio_nbits-1:0] csr_ctrl_addr = 32'h0000_8000;
	localparam logic [pio_nbits-1:0] csr_default_addr = 32'h0000_8004;
	localparam logic [pio_nbits-1:0] csr_hit_addr = 32'h0000_8008;
	localparam logic [pio_nbits-1:0] csr_miss_addr = 32'h0000_800C;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Payload types
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef struct packed {
		logic valid;
		logic [key_nbits-1:0] key;
		logic [action_nbits-1:0] action;
	} flow_entry_t;

	typedef struct packed {
		logic [key_nbits-1:0] key;
	} lookup_req_t;

	typedef struct packed {
		logic hit;
		logic [action_nbits-1:0] action;
	} lookup_rsp_t;

	typedef struct packed {
		logic [pio_nbits-1:0] addr;
		logic [pio_nbits-1:0] wdata;
		logic rd;
		logic wr;
	} pio_req_t;

endpackage
